// File: Bender.yml
package:
  name: ppu_out

sources:
  # Design, packages first
  - logic/ppu_cfg_pkg.sv
  - logic/ppu_video_pkg.sv
  - logic/cfg_resync.sv
  - logic/ppu_cfg_decoder.sv
  - logic/rgb_range_limiter.sv
  - logic/ppu_out_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - tb/ppu_out_assert.sv
      - tb/tb_ppu_out_top.sv

// File: logic/cfg_resync.sv
// Brings a quasi-static word from another clock domain into VCLK_Tx
// Only safe for levels that change rarely; bits are not sampled coherently
// SYNC_STAGES must be at least 2, first stage is a timing false path

`timescale 1ns/1ps

module cfg_resync #(
  parameter int WIDTH       = 16,
  parameter int SYNC_STAGES = 2
) (
  input  logic             VCLK_Tx,
  input  logic             nVRST_Tx,
  input  logic [WIDTH-1:0] d_i,
  output logic [WIDTH-1:0] q_o
);

  logic [WIDTH-1:0] sync_q [SYNC_STAGES];

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      // Capture stage, may go metastable
      sync_q[0] <= d_i;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign q_o = sync_q[SYNC_STAGES-1];

endmodule

// File: logic/ppu_cfg_decoder.sv
// Decodes the resynchronised configuration into the output video mode
// Inputs must already be in VCLK_Tx, all outputs are registered once
// Forcing 50/60 Hz is ignored in low latency mode and for low-res targets

`timescale 1ns/1ps

module ppu_cfg_decoder
  import ppu_cfg_pkg::*;
(
  input  logic       VCLK_Tx,
  input  logic       nVRST_Tx,
  input  cfg_word_t  cfg_i,
  input  vinfo_t     vinfo_i,
  output mode_cfg_t  mode_cfg_o,
  output logic       limited_en_o,
  output ppu_state_t ppu_state_o
);

  video_mode_e ntsc_mode;
  video_mode_e pal_mode;
  video_mode_e next_mode;
  logic        is_lowres;
  logic        allow_force;
  logic        use_pal;
  logic        hd_mode;

  // ====================
  // Candidate modes
  // ====================
  always_comb begin
    case (cfg_i.target_res)
      RES_720: begin
        ntsc_mode = MODE_720P60;
        pal_mode  = MODE_720P50;
      end
      RES_960: begin
        ntsc_mode = MODE_960P60;
        pal_mode  = MODE_960P50;
      end
      RES_1080: begin
        ntsc_mode = MODE_1080P60;
        pal_mode  = MODE_1080P50;
      end
      RES_1200: begin
        ntsc_mode = MODE_1200P60;
        pal_mode  = MODE_1200P50;
      end
      RES_1440: begin
        ntsc_mode = MODE_1440P60;
        pal_mode  = MODE_1440P50;
      end
      RES_LOWRES: begin
        ntsc_mode = MODE_240P60;
        pal_mode  = MODE_288P50;
      end
      // RES_SD and unknown codes
      default: begin
        ntsc_mode = cfg_i.use_vga_480p ? MODE_VGA60 : MODE_480P60;
        pal_mode  = MODE_576P50;
      end
    endcase
  end

  // ====================
  // Rate selection
  // ====================
  assign is_lowres   = (cfg_i.target_res == RES_LOWRES);
  assign allow_force = !cfg_i.low_latency && !is_lowres;

  always_comb begin
    if (cfg_i.force60 && allow_force) begin
      use_pal = 1'b0;
    end else if (cfg_i.force50 && allow_force) begin
      use_pal = 1'b1;
    end else begin
      use_pal = vinfo_i.pal;
    end
  end

  assign next_mode = use_pal ? pal_mode : ntsc_mode;

  // Syncs are active high from 720 lines upwards
  assign hd_mode = !(next_mode inside {MODE_480P60, MODE_VGA60, MODE_240P60,
                                       MODE_576P50, MODE_288P50});

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      mode_cfg_o.mode              <= MODE_480P60;
      mode_cfg_o.interp_mode       <= 2'b00;
      mode_cfg_o.pal_boxed         <= 1'b0;
      mode_cfg_o.hsync_active_high <= 1'b0;
      mode_cfg_o.vsync_active_high <= 1'b0;
      limited_en_o                 <= 1'b0;
      ppu_state_o                  <= '0;
    end else begin
      mode_cfg_o.mode              <= next_mode;
      mode_cfg_o.interp_mode       <= is_lowres ? 2'b00 : cfg_i.interp_mode;
      mode_cfg_o.pal_boxed         <= cfg_i.pal_boxed;
      mode_cfg_o.hsync_active_high <= hd_mode;
      mode_cfg_o.vsync_active_high <= hd_mode;
      limited_en_o                 <= cfg_i.limited_rgb;
      // Status readback
      ppu_state_o.in_pal           <= vinfo_i.pal;
      ppu_state_o.in_interlaced    <= vinfo_i.interlaced;
      ppu_state_o.force60          <= cfg_i.force60;
      ppu_state_o.force50          <= cfg_i.force50;
      ppu_state_o.use_vga_480p     <= cfg_i.use_vga_480p;
      ppu_state_o.target_res       <= cfg_i.target_res;
      ppu_state_o.low_latency      <= cfg_i.low_latency;
      ppu_state_o.reserved         <= 2'b00;
    end
  end

endmodule

// File: logic/ppu_cfg_pkg.sv
// Configuration word layout and video mode types of the VCLK_Tx output side
// target_res codes above RES_LOWRES are handled as RES_SD by the decoder
// Field order of cfg_word_t fixes the bit layout seen by the controller

package ppu_cfg_pkg;

  // ====================
  // Configuration word
  // ====================
  typedef struct packed {
    logic [3:0] target_res;
    logic       use_vga_480p;
    logic       force60;
    logic       force50;
    logic       low_latency;
    logic [1:0] interp_mode;
    logic       pal_boxed;
    logic       limited_rgb;
    logic [3:0] reserved;
  } cfg_word_t;

  // Target resolution codes
  localparam logic [3:0] RES_SD     = 4'd0;  // 480p or 576p
  localparam logic [3:0] RES_720    = 4'd1;
  localparam logic [3:0] RES_960    = 4'd2;
  localparam logic [3:0] RES_1080   = 4'd3;
  localparam logic [3:0] RES_1200   = 4'd4;
  localparam logic [3:0] RES_1440   = 4'd5;
  localparam logic [3:0] RES_LOWRES = 4'd6;  // 240p or 288p

  // ====================
  // Output video modes
  // ====================
  typedef enum logic [3:0] {
    MODE_480P60 = 4'd0,
    MODE_VGA60,
    MODE_240P60,
    MODE_720P60,
    MODE_960P60,
    MODE_1080P60,
    MODE_1200P60,
    MODE_1440P60,
    MODE_576P50,
    MODE_288P50,
    MODE_720P50,
    MODE_960P50,
    MODE_1080P50,
    MODE_1200P50,
    MODE_1440P50
  } video_mode_e;

  // Input video information from the N64 side
  typedef struct packed {
    logic pal;
    logic interlaced;
  } vinfo_t;

  typedef struct packed {
    video_mode_e mode;
    logic [1:0]  interp_mode;
    logic        pal_boxed;
    logic        hsync_active_high;
    logic        vsync_active_high;
  } mode_cfg_t;

  // Status word read back by the controller
  typedef struct packed {
    logic       in_pal;
    logic       in_interlaced;
    logic       force60;
    logic       force50;
    logic       use_vga_480p;
    logic [3:0] target_res;
    logic       low_latency;
    logic [1:0] reserved;
  } ppu_state_t;

endpackage

// File: logic/ppu_out_top.sv
// VCLK_Tx output side of the post-processing unit
// cfg_i and vinfo_i are quasi-static levels from other clock domains
// pix_i carries one pixel per cycle, there is no back-pressure

`timescale 1ns/1ps

module ppu_out_top
  import ppu_cfg_pkg::*;
  import ppu_video_pkg::*;
(
  input  logic       VCLK_Tx,
  input  logic       nVRST_Tx,
  input  cfg_word_t  cfg_i,
  input  vinfo_t     vinfo_i,
  input  pixel_t     pix_i,
  output pixel_t     pix_o,
  output mode_cfg_t  mode_cfg_o,
  output ppu_state_t ppu_state_o
);

  cfg_word_t cfg_synced;
  vinfo_t    vinfo_synced;
  logic      limited_en;

  // ====================
  // Clock crossing
  // ====================
  cfg_resync #(
    .WIDTH      ($bits(cfg_word_t)),
    .SYNC_STAGES(2)
  ) cfg_sync_u (
    .VCLK_Tx (VCLK_Tx),
    .nVRST_Tx(nVRST_Tx),
    .d_i     (cfg_i),
    .q_o     (cfg_synced)
  );

  // One extra stage on the video info path
  cfg_resync #(
    .WIDTH      ($bits(vinfo_t)),
    .SYNC_STAGES(3)
  ) vinfo_sync_u (
    .VCLK_Tx (VCLK_Tx),
    .nVRST_Tx(nVRST_Tx),
    .d_i     (vinfo_i),
    .q_o     (vinfo_synced)
  );

  ppu_cfg_decoder cfg_decoder_u (
    .VCLK_Tx     (VCLK_Tx),
    .nVRST_Tx    (nVRST_Tx),
    .cfg_i       (cfg_synced),
    .vinfo_i     (vinfo_synced),
    .mode_cfg_o  (mode_cfg_o),
    .limited_en_o(limited_en),
    .ppu_state_o (ppu_state_o)
  );

  // ====================
  // Pixel path
  // ====================
  rgb_range_limiter range_limiter_u (
    .VCLK_Tx     (VCLK_Tx),
    .nVRST_Tx    (nVRST_Tx),
    .limited_en_i(limited_en),
    .pix_i       (pix_i),
    .pix_o       (pix_o)
  );

endmodule

// File: logic/ppu_video_pkg.sv
// Pixel format of the output video path
// Range constants assume COLOR_W of 8, i.e. 16..235 limited range

package ppu_video_pkg;

  localparam int COLOR_W = 8;

  // Limited range is x * 220/256 + 16
  localparam logic [COLOR_W-1:0] LIMIT_COEFF  = COLOR_W'(220);
  localparam logic [COLOR_W-1:0] LIMIT_OFFSET = COLOR_W'(16);

  // ====================
  // Pixel bundle
  // ====================
  // One pixel per VCLK_Tx cycle, de marks active video
  typedef struct packed {
    logic               vsync;
    logic               de;
    logic               hsync;
    logic [COLOR_W-1:0] red;
    logic [COLOR_W-1:0] green;
    logic [COLOR_W-1:0] blue;
  } pixel_t;

endpackage

// File: logic/rgb_range_limiter.sv
// Final pixel stage, fixed latency of three VCLK_Tx cycles for all fields
// limited_en_i acts on stage 3, so a change hits pixels already in flight
// Limited range result is round(x * 220/256) + 16, i.e. 16..235

`timescale 1ns/1ps

module rgb_range_limiter
  import ppu_video_pkg::*;
(
  input  logic   VCLK_Tx,
  input  logic   nVRST_Tx,
  input  logic   limited_en_i,
  input  pixel_t pix_i,
  output pixel_t pix_o
);

  localparam int NCH = 3;

  // Channel 2 is red, 1 green, 0 blue
  logic [NCH-1:0][COLOR_W-1:0]   chan_in;
  logic [NCH-1:0][2*COLOR_W-1:0] product;
  logic [NCH-1:0][COLOR_W:0]     scaled_q;
  logic [NCH-1:0][COLOR_W-1:0]   rounded_q;
  logic [NCH-1:0][COLOR_W-1:0]   offset_rgb;
  pixel_t                        pix_s1_q;
  pixel_t                        pix_s2_q;
  pixel_t                        pix_s3_q;

  assign chan_in = {pix_i.red, pix_i.green, pix_i.blue};

  always_comb begin
    for (int c = 0; c < NCH; c++) begin
      product[c]    = chan_in[c] * LIMIT_COEFF;
      offset_rgb[c] = rounded_q[c] + LIMIT_OFFSET;
    end
  end

  // ====================
  // Stages 1 and 2
  // ====================
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      scaled_q  <= '0;
      rounded_q <= '0;
    end else begin
      for (int c = 0; c < NCH; c++) begin
        // Keep one bit below the /256 point for rounding
        scaled_q[c]  <= product[c][2*COLOR_W-1:COLOR_W-1];
        rounded_q[c] <= scaled_q[c][COLOR_W:1] + {{(COLOR_W-1){1'b0}}, scaled_q[c][0]};
      end
    end
  end

  // Syncs, DE and full range RGB ride alongside the math
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      pix_s1_q <= '0;
      pix_s2_q <= '0;
    end else begin
      pix_s1_q <= pix_i;
      pix_s2_q <= pix_s1_q;
    end
  end

  // ====================
  // Stage 3
  // ====================
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      pix_s3_q <= '0;
    end else begin
      pix_s3_q <= pix_s2_q;
      if (limited_en_i) begin
        pix_s3_q.red   <= offset_rgb[2];
        pix_s3_q.green <= offset_rgb[1];
        pix_s3_q.blue  <= offset_rgb[0];
      end
    end
  end

  assign pix_o = pix_s3_q;

endmodule

// File: project.f
logic/ppu_cfg_pkg.sv
logic/ppu_video_pkg.sv
logic/cfg_resync.sv
logic/ppu_cfg_decoder.sv
logic/rgb_range_limiter.sv
logic/ppu_out_top.sv
tb/ppu_out_assert.sv
tb/tb_ppu_out_top.sv

// File: tb/ppu_out_assert.sv
// Concurrent checks on the range limiter, attached with bind
// Range bounds follow LIMIT_OFFSET and LIMIT_COEFF of ppu_video_pkg

`timescale 1ns/1ps

module ppu_out_assert
  import ppu_video_pkg::*;
(
  input logic   VCLK_Tx,
  input logic   nVRST_Tx,
  input logic   limited_en_i,
  input pixel_t pix_i,
  input pixel_t pix_o
);

  localparam int LO = int'(LIMIT_OFFSET);
  localparam int HI = int'(LIMIT_OFFSET) + int'(LIMIT_COEFF) - 1;

  int unsigned fail_count = 0;

  function automatic logic in_range(input logic [COLOR_W-1:0] x);
    return (int'(x) >= LO) && (int'(x) <= HI);
  endfunction

  // DE leaves exactly three cycles after it enters
  de_latency_a: assert property (
    @(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    pix_o.de == $past(pix_i.de, 3)
  ) else begin
    fail_count++;
    $error("pix_o.de differs from pix_i.de three cycles earlier");
  end

  limited_range_a: assert property (
    @(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    (pix_o.de && limited_en_i && $past(limited_en_i, 1) && $past(limited_en_i, 2))
      |-> (in_range(pix_o.red) && in_range(pix_o.green) && in_range(pix_o.blue))
  ) else begin
    fail_count++;
    $error("Limited range pixel channel outside 16..235");
  end

endmodule

bind rgb_range_limiter ppu_out_assert limiter_checks_u (
  .VCLK_Tx     (VCLK_Tx),
  .nVRST_Tx    (nVRST_Tx),
  .limited_en_i(limited_en_i),
  .pix_i       (pix_i),
  .pix_o       (pix_o)
);

// File: tb/tb_ppu_out_top.sv
// Directed testbench for ppu_out_top
// Config checks wait CFG_WAIT cycles so cfg_i and vinfo_i have fully crossed
// Pixel checks rely on the fixed three-cycle latency of the pixel path

`timescale 1ns/1ps

module tb_ppu_out_top
  import ppu_cfg_pkg::*;
  import ppu_video_pkg::*;
();

  localparam int RESET_CYCLES = 8;
  localparam int CFG_WAIT     = 6;
  localparam int CFG_STEP     = CFG_WAIT + 2;
  localparam int NUM_PIX      = 200;
  // Reset, 64 table entries, 48 forcing cases, two pixel streams, margin
  localparam int TIMEOUT_CYCLES = 2 * RESET_CYCLES + 64 * CFG_STEP + 48 * CFG_STEP
                                  + 2 * (CFG_STEP + NUM_PIX + 4) + 200;

  logic        VCLK_Tx = 1'b0;
  logic        nVRST_Tx;
  cfg_word_t   cfg_i;
  vinfo_t      vinfo_i;
  pixel_t      pix_i;
  pixel_t      pix_o;
  mode_cfg_t   mode_cfg_o;
  ppu_state_t  ppu_state_o;
  logic [31:0] rng_state   = 32'h2f68_011a;
  int          checks_done = 0;
  int          mismatches  = 0;
  int          cycle_count = 0;
  int          assert_fails;

  ppu_out_top ppu_out_top_i (
    .VCLK_Tx    (VCLK_Tx),
    .nVRST_Tx   (nVRST_Tx),
    .cfg_i      (cfg_i),
    .vinfo_i    (vinfo_i),
    .pix_i      (pix_i),
    .pix_o      (pix_o),
    .mode_cfg_o (mode_cfg_o),
    .ppu_state_o(ppu_state_o)
  );

  always #2 VCLK_Tx = ~VCLK_Tx;

  always @(posedge VCLK_Tx) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout, the tests did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // ====================
  // Reference model
  // ====================
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Nearest integer of x * 220/256 with halves rounded up, then offset
  function automatic logic [7:0] limit_chan(input logic [7:0] x);
    int scaled;
    scaled = (int'(x) * 220 + 128) / 256;
    return 8'(scaled + 16);
  endfunction

  function automatic logic [3:0] eff_res(input logic [3:0] res);
    return (res > RES_LOWRES) ? RES_SD : res;
  endfunction

  function automatic video_mode_e expect_mode(input cfg_word_t c, input logic pal);
    logic [3:0] res;
    logic       pal_rate;
    logic       can_force;
    res       = eff_res(c.target_res);
    can_force = !c.low_latency && (res != RES_LOWRES);
    if (c.force60 && can_force) pal_rate = 1'b0;
    else if (c.force50 && can_force) pal_rate = 1'b1;
    else pal_rate = pal;
    if (res == RES_LOWRES) return pal_rate ? MODE_288P50 : MODE_240P60;
    if (res == RES_SD) return pal_rate ? MODE_576P50 : (c.use_vga_480p ? MODE_VGA60 : MODE_480P60);
    // 720 to 1440 follow the enum order of each rate
    return pal_rate ? video_mode_e'(MODE_720P50 + res - 1) : video_mode_e'(MODE_720P60 + res - 1);
  endfunction

  function automatic ppu_state_t expect_state(input cfg_word_t c, input vinfo_t v);
    ppu_state_t s;
    s               = '0;
    s.in_pal        = v.pal;
    s.in_interlaced = v.interlaced;
    s.force60       = c.force60;
    s.force50       = c.force50;
    s.use_vga_480p  = c.use_vga_480p;
    s.target_res    = c.target_res;
    s.low_latency   = c.low_latency;
    return s;
  endfunction

  // ====================
  // Check helpers
  // ====================
  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks_done++;
    if (got !== exp) begin
      mismatches++;
      $display("** Error: time %0t, %s = 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("Test %-12s finished with %0d mismatches", name, mismatches - errs_before);
  endtask

  task automatic apply_cfg(input cfg_word_t c, input vinfo_t v);
    @(posedge VCLK_Tx);
    cfg_i   <= c;
    vinfo_i <= v;
    repeat (CFG_WAIT) @(posedge VCLK_Tx);
    @(negedge VCLK_Tx);
  endtask

  task automatic check_mode(input cfg_word_t c, input vinfo_t v);
    logic [3:0] res;
    logic       hd;
    res = eff_res(c.target_res);
    hd  = (res != RES_SD) && (res != RES_LOWRES);
    compare("mode_cfg_o.mode", mode_cfg_o.mode, expect_mode(c, v.pal));
    compare("mode_cfg_o.interp_mode", mode_cfg_o.interp_mode,
            (res == RES_LOWRES) ? 2'b00 : c.interp_mode);
    compare("mode_cfg_o.pal_boxed", mode_cfg_o.pal_boxed, c.pal_boxed);
    compare("mode_cfg_o.hsync_active_high", mode_cfg_o.hsync_active_high, hd);
    compare("mode_cfg_o.vsync_active_high", mode_cfg_o.vsync_active_high, hd);
    compare("ppu_state_o", ppu_state_o, expect_state(c, v));
  endtask

  task automatic check_idle_outputs();
    compare("pix_o", pix_o, '0);
    compare("mode_cfg_o.mode", mode_cfg_o.mode, MODE_480P60);
    compare("mode_cfg_o.hsync_active_high", mode_cfg_o.hsync_active_high, 1'b0);
    compare("mode_cfg_o.vsync_active_high", mode_cfg_o.vsync_active_high, 1'b0);
    compare("ppu_state_o", ppu_state_o, '0);
  endtask

  task automatic stream_pixels(input logic limited);
    pixel_t      p;
    pixel_t      exp;
    pixel_t      exp_q[$];
    logic [31:0] r;
    for (int i = 0; i < NUM_PIX + 3; i++) begin
      r = next_random();
      p = pixel_t'(r[26:0]);
      // All zero and all ones first
      if (i < 2) begin
        p.red   = {8{i[0]}};
        p.green = {8{i[0]}};
        p.blue  = {8{i[0]}};
      end
      exp = p;
      if (limited) begin
        exp.red   = limit_chan(p.red);
        exp.green = limit_chan(p.green);
        exp.blue  = limit_chan(p.blue);
      end
      exp_q.push_back(exp);
      @(posedge VCLK_Tx);
      pix_i <= p;
      @(negedge VCLK_Tx);
      if (exp_q.size() > 3) begin
        exp = exp_q.pop_front();
        compare("pix_o.red", pix_o.red, exp.red);
        compare("pix_o.green", pix_o.green, exp.green);
        compare("pix_o.blue", pix_o.blue, exp.blue);
        compare("pix_o.{vsync,de,hsync}", {pix_o.vsync, pix_o.de, pix_o.hsync},
                {exp.vsync, exp.de, exp.hsync});
      end
    end
    @(posedge VCLK_Tx);
    pix_i <= '0;
  endtask

  // ====================
  // Tests
  // ====================
  task automatic test_reset();
    int errs;
    errs = mismatches;
    repeat (RESET_CYCLES / 2) @(posedge VCLK_Tx);
    @(negedge VCLK_Tx);
    check_idle_outputs();
    repeat (RESET_CYCLES / 2) @(posedge VCLK_Tx);
    nVRST_Tx <= 1'b1;
    repeat (2) @(negedge VCLK_Tx);
    check_idle_outputs();
    report_test("reset", errs);
  endtask

  task automatic test_mode_table();
    cfg_word_t c;
    vinfo_t    v;
    int        errs;
    errs = mismatches;
    for (int res = 0; res < 16; res++) begin
      for (int pal = 0; pal < 2; pal++) begin
        for (int vga = 0; vga < 2; vga++) begin
          c              = '0;
          c.target_res   = 4'(res);
          c.use_vga_480p = vga[0];
          c.interp_mode  = 2'(res + 1);
          c.pal_boxed    = pal[0];
          v.pal          = pal[0];
          v.interlaced   = vga[0];
          apply_cfg(c, v);
          check_mode(c, v);
        end
      end
    end
    report_test("mode_table", errs);
  endtask

  task automatic test_forcing();
    logic [3:0] targets [3];
    cfg_word_t  c;
    vinfo_t     v;
    int         errs;
    errs    = mismatches;
    targets = '{RES_SD, RES_1080, RES_LOWRES};
    for (int t = 0; t < 3; t++) begin
      for (int bits = 0; bits < 16; bits++) begin
        c             = '0;
        c.target_res  = targets[t];
        c.interp_mode = 2'b11;
        c.force60     = bits[0];
        c.force50     = bits[1];
        c.low_latency = bits[2];
        v             = '0;
        v.pal         = bits[3];
        apply_cfg(c, v);
        check_mode(c, v);
      end
    end
    report_test("forcing", errs);
  endtask

  task automatic test_pixels(input string name, input logic limited);
    cfg_word_t c;
    vinfo_t    v;
    int        errs;
    errs           = mismatches;
    c              = '0;
    c.limited_rgb  = limited;
    c.target_res   = limited ? RES_1080 : RES_960;
    c.force50      = !limited;
    c.use_vga_480p = 1'b1;
    c.low_latency  = limited;
    v.pal          = 1'b1;
    v.interlaced   = !limited;
    apply_cfg(c, v);
    compare("ppu_state_o", ppu_state_o, expect_state(c, v));
    stream_pixels(limited);
    report_test(name, errs);
  endtask

  initial begin
    nVRST_Tx = 1'b0;
    cfg_i    = '0;
    vinfo_i  = '0;
    pix_i    = '0;
    test_reset();
    test_mode_table();
    test_forcing();
    test_pixels("limited_rgb", 1'b1);
    test_pixels("full_rgb", 1'b0);
    assert_fails = ppu_out_top_i.range_limiter_u.limiter_checks_u.fail_count;
    $display("Summary: %0d checks, %0d mismatches, %0d assertion failures",
             checks_done, mismatches, assert_fails);
    if (mismatches == 0 && assert_fails == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
